// File: sim/processorTb.sv
`timescale 1ns/1ps

module processorTb import cpuPkg::*; ();

	logic clk;
	logic rst;
	logic progWe;
	logic [memAddrWidth-1:0] progAddr;
	logic [dataWidth-1:0] progData;
	logic [regAddrWidth-1:0] dbgSel;
	logic [dataWidth-1:0] dbgData;
	logic storeValid;
	logic [dataWidth-1:0] storeAddr;
	logic [dataWidth-1:0] storeData;

	// Program table and the instruction-level model state
	logic [dataWidth-1:0] progMem [memDepth];
	int progLen;
	int execCount;
	logic [dataWidth-1:0] mReg [regCount];
	logic [dataWidth-1:0] mMem [memDepth];
	logic mCarry;
	logic mZero;

	// Expected stores in program order
	logic [dataWidth-1:0] expStoreAddr [$];
	logic [dataWidth-1:0] expStoreData [$];
	int storeCount;

	int cycleCount = 0;
	int cycleLimit = 100000;

	processorTop i_dut (
		.clk(clk),
		.rst(rst),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.dbgSel(dbgSel),
		.dbgData(dbgData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped on first error");
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			abortRun($sformatf("Timeout after %0d cycles", cycleCount));
		end
	end

	// Append one instruction; when run is set, apply it to the model
	task automatic emit(input opcodeT op, input int d, input int s, input int imm, input bit run);
		logic [dataWidth-1:0] word;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] res;
		logic carry;
		int amt;
		int sum;
		if (op inside {LDI, JMP, JZ, JC}) begin
			word = {op, d[3:0], imm[7:0]};
		end else begin
			word = {op, d[3:0], s[3:0], 4'h0};
		end
		progMem[progLen] = word;
		progLen++;
		if (run) begin
			execCount++;
			a = mReg[d];
			b = mReg[s];
			amt = b[3:0];
			carry = 1'b0;
			res = a;
			case (op)
				ADD: begin
					sum = int'(a) + int'(b);
					res = a + b;
					carry = (sum > 65535);
				end
				SUB: begin
					res = a - b;
					carry = (a < b);
				end
				AND: res = a & b;
				OR: res = a | b;
				XOR: res = a ^ b;
				SHL: begin
					res = a << amt;
					carry = (amt != 0) && a[16 - amt];
				end
				SHR: begin
					res = a >> amt;
					carry = (amt != 0) && a[amt - 1];
				end
				default: res = a;
			endcase
			if (op inside {ADD, SUB, AND, OR, XOR, SHL, SHR}) begin
				mReg[d] = res;
				mCarry = carry;
				mZero = (res == 16'h0000);
			end else if (op == MOV) begin
				mReg[d] = b;
			end else if (op == LDI) begin
				mReg[d] = imm & 8'hff;
			end else if (op == LD) begin
				mReg[d] = mMem[b[memAddrWidth-1:0]];
			end else if (op == ST) begin
				mMem[a[memAddrWidth-1:0]] = b;
				expStoreAddr.push_back(a);
				expStoreData.push_back(b);
			end
		end
	endtask

	// Conditional jump with a marker store on each path
	task automatic condBranch(input opcodeT op, input int markAddr);
		bit taken;
		int base;
		emit(LDI, 15, 0, markAddr, 1'b1);
		taken = (op == JZ) ? mZero : mCarry;
		base = progLen;
		emit(op, 0, 0, base + 3, 1'b1);
		emit(ST, 15, 13, 0, !taken);
		emit(JMP, 0, 0, base + 4, !taken);
		emit(ST, 15, 14, 0, taken);
	endtask

	task automatic buildProgram();
		int cA;
		int cB;
		int sh;
		int memA;
		int memB;
		int base;
		cA = $urandom & 8'hff;
		cB = $urandom & 8'hff;
		sh = $urandom % 15 + 1;
		memA = 8'h40 | ($urandom & 8'h3f);
		// Same cell as memA once the upper address bit is dropped
		memB = memA | 8'h80;

		// Word 0 is a store, so the core sees a ST while still in reset
		emit(ST, 0, 0, 0, 1'b1);

		// Path markers
		emit(LDI, 13, 0, 8'h5a, 1'b1);
		emit(LDI, 14, 0, 8'ha5, 1'b1);
		emit(LDI, 1, 0, cA, 1'b1);
		emit(LDI, 2, 0, cB, 1'b1);
		emit(MOV, 3, 1, 0, 1'b1);
		emit(ADD, 3, 2, 0, 1'b1);
		emit(MOV, 4, 1, 0, 1'b1);
		emit(SUB, 4, 2, 0, 1'b1);
		emit(MOV, 5, 1, 0, 1'b1);
		emit(AND, 5, 2, 0, 1'b1);
		emit(MOV, 6, 1, 0, 1'b1);
		emit(OR, 6, 2, 0, 1'b1);
		emit(MOV, 7, 1, 0, 1'b1);
		emit(XOR, 7, 2, 0, 1'b1);
		emit(LDI, 8, 0, sh, 1'b1);
		emit(MOV, 9, 1, 0, 1'b1);
		emit(SHL, 9, 8, 0, 1'b1);
		emit(MOV, 10, 3, 0, 1'b1);
		emit(SHR, 10, 8, 0, 1'b1);

		// 0x00ff << 8 doubled so the add wraps with carry
		emit(LDI, 11, 0, 8'hff, 1'b1);
		emit(LDI, 12, 0, 8, 1'b1);
		emit(SHL, 11, 12, 0, 1'b1);
		emit(ADD, 11, 11, 0, 1'b1);
		// Zero results here must not touch the flags
		emit(LDI, 12, 0, 0, 1'b1);
		emit(MOV, 12, 0, 0, 1'b1);
		condBranch(JC, 8'h10);
		condBranch(JZ, 8'h11);

		emit(MOV, 12, 1, 0, 1'b1);
		emit(XOR, 12, 1, 0, 1'b1);
		emit(LDI, 12, 0, 8'h77, 1'b1);
		emit(MOV, 12, 2, 0, 1'b1);
		condBranch(JZ, 8'h12);
		condBranch(JC, 8'h13);

		// 0 - 1 wraps to 0xffff with borrow
		emit(MOV, 12, 0, 0, 1'b1);
		emit(LDI, 11, 0, 1, 1'b1);
		emit(SUB, 12, 11, 0, 1'b1);
		condBranch(JC, 8'h14);

		// Store and load back, including an aliased address
		emit(LDI, 15, 0, memA, 1'b1);
		emit(ST, 15, 3, 0, 1'b1);
		emit(LD, 11, 15, 0, 1'b1);
		emit(LDI, 15, 0, memB, 1'b1);
		emit(ST, 15, 4, 0, 1'b1);
		emit(LDI, 15, 0, memA, 1'b1);
		emit(LD, 12, 15, 0, 1'b1);
		emit(LDI, 15, 0, 8'h20, 1'b1);
		emit(ST, 15, 11, 0, 1'b1);

		// Register jump over one store
		base = progLen;
		emit(LDI, 15, 0, base + 3, 1'b1);
		emit(JR, 0, 15, 0, 1'b1);
		emit(ST, 15, 13, 0, 1'b0);
		emit(ST, 15, 14, 0, 1'b1);

		emit(JMP, 0, 0, progLen, 1'b1);
	endtask

	// One cycle of the run with the store bus sampled mid-cycle
	task automatic sampleCycle();
		@(negedge clk);
		assert (storeValid !== 1'bx) else abortRun("storeValid is unknown during the run");
		if (storeValid) begin
			assert (storeCount < expStoreAddr.size())
			else abortRun("A store appeared after the last expected store");
			assert (storeAddr === expStoreAddr[storeCount])
			else abortRun($sformatf("Fail storeAddr: expected 0x%h, got 0x%h",
				expStoreAddr[storeCount], storeAddr));
			assert (storeData === expStoreData[storeCount])
			else abortRun($sformatf("Fail storeData: expected 0x%h, got 0x%h",
				expStoreData[storeCount], storeData));
			storeCount++;
		end
	endtask

	initial begin
		int unsigned seed;
		int unsigned rnd;
		seed = 32'hf0957aed;
		rnd = $urandom(seed);
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		dbgSel = '0;
		progLen = 0;
		execCount = 0;
		storeCount = 0;
		mCarry = 1'b0;
		mZero = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			mReg[i] = '0;
		end
		for (int i = 0; i < memDepth; i++) begin
			mMem[i] = '0;
		end
		buildProgram();
		cycleLimit = 10 + progLen + execCount + 10 + regCount + 50;

		repeat (10) @(posedge clk);

		// Boot load while reset holds the core and every register reads zero
		for (int k = 0; k < progLen; k++) begin
			@(posedge clk);
			progWe <= 1'b1;
			progAddr <= k[memAddrWidth-1:0];
			progData <= progMem[k];
			dbgSel <= k[regAddrWidth-1:0];
			@(negedge clk);
			assert (storeValid === 1'b0) else abortRun("storeValid was not low during reset");
			assert (dbgData === 16'h0000)
			else abortRun($sformatf("Fail dbgData[r%0d]: expected 0x%h, got 0x%h",
				k % regCount, 16'h0000, dbgData));
		end

		@(posedge clk);
		rst <= 1'b0;
		progWe <= 1'b0;

		// Program plus some self-loop cycles that must stay quiet
		for (int c = 0; c < execCount + 10; c++) begin
			sampleCycle();
			if (c < execCount + 9) begin
				@(posedge clk);
			end
		end
		assert (storeCount == expStoreAddr.size())
		else abortRun($sformatf("Only %0d of %0d expected stores were seen",
			storeCount, expStoreAddr.size()));

		for (int r = 0; r < regCount; r++) begin
			@(posedge clk);
			dbgSel <= r[regAddrWidth-1:0];
			sampleCycle();
			assert (dbgData === mReg[r])
			else abortRun($sformatf("Fail dbgData[r%0d]: expected 0x%h, got 0x%h",
				r, mReg[r], dbgData));
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input opcodeT op,
	input logic flagWe,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	output logic [dataWidth-1:0] result,
	output logic cFlag,
	output logic zFlag
);

	logic [dataWidth:0] wide;
	logic [dataWidth-1:0] resultNext;
	logic carryNext;
	logic [shiftWidth-1:0] shAmt;

	always_comb begin
		shAmt = b[shiftWidth-1:0];
		wide = '0;
		resultNext = a;
		carryNext = 1'b0;
		case (op)
			ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				resultNext = wide[dataWidth-1:0];
				carryNext = wide[dataWidth];
			end
			// Top bit of the wide difference is the borrow
			SUB: begin
				wide = {1'b0, a} - {1'b0, b};
				resultNext = wide[dataWidth-1:0];
				carryNext = wide[dataWidth];
			end
			AND: resultNext = a & b;
			OR: resultNext = a | b;
			XOR: resultNext = a ^ b;
			// Last bit pushed out lands in the extra top bit
			SHL: begin
				wide = {1'b0, a} << shAmt;
				resultNext = wide[dataWidth-1:0];
				carryNext = wide[dataWidth];
			end
			// Extra bit below the LSB catches what falls off
			SHR: begin
				wide = {a, 1'b0} >> shAmt;
				resultNext = wide[dataWidth:1];
				carryNext = wide[0];
			end
			MOV: resultNext = b;
			default: resultNext = a;
		endcase
	end

	assign result = resultNext;

	// Flags only move on ALU ops
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagWe) begin
			cFlag <= carryNext;
			zFlag <= (resultNext == '0);
		end
	end

endmodule

// File: source/cpuPkg.sv
package cpuPkg;

	// Word width of registers, data, instructions and PC
	localparam int dataWidth = 16;

	localparam int regCount = 16;
	localparam int regAddrWidth = 4;

	// Both memories share one depth, upper address bits are dropped
	localparam int memDepth = 128;
	localparam int memAddrWidth = 7;

	// Shift amount comes from the low bits of the source operand
	localparam int shiftWidth = $clog2(dataWidth);

	// Writeback source codes
	localparam logic [1:0] wbAlu = 2'd0;
	localparam logic [1:0] wbImm = 2'd1;
	localparam logic [1:0] wbMem = 2'd2;

	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		SHR = 4'h6,
		MOV = 4'h7,
		LDI = 4'h8,
		LD  = 4'h9,
		ST  = 4'ha,
		JMP = 4'hb,
		JZ  = 4'hc,
		JC  = 4'hd,
		JR  = 4'he,
		NOP = 4'hf
	} opcodeT;

	typedef enum logic [1:0] {
		PC_INC = 2'd0,
		PC_IMM = 2'd1,
		PC_REG = 2'd2
	} pcSelT;

	// Decoded control word
	typedef struct packed {
		opcodeT op;
		logic [regAddrWidth-1:0] regDst;
		logic [regAddrWidth-1:0] regSrc;
		logic [dataWidth-1:0] imm;
		logic regWe;
		logic memWe;
		logic flagWe;
		logic [1:0] wbSel;
	} ctrlT;

endpackage

// File: source/decoder.sv
`timescale 1ns/1ps

module decoder import cpuPkg::*; (
	input logic [dataWidth-1:0] instr,
	input logic cFlag,
	input logic zFlag,
	output ctrlT ctrl,
	output pcSelT pcSel
);

	opcodeT op;

	assign op = opcodeT'(instr[15:12]);

	always_comb begin
		// Field split is the same for every opcode
		ctrl.op = op;
		ctrl.regDst = instr[11:8];
		ctrl.regSrc = instr[7:4];
		ctrl.imm = dataWidth'(instr[7:0]);

		ctrl.regWe = 1'b0;
		ctrl.memWe = 1'b0;
		ctrl.flagWe = 1'b0;
		ctrl.wbSel = wbAlu;
		pcSel = PC_INC;

		case (op)
			ADD, SUB, AND, OR, XOR, SHL, SHR: begin
				ctrl.regWe = 1'b1;
				ctrl.flagWe = 1'b1;
			end
			// ALU passes src through, flags untouched
			MOV: begin
				ctrl.regWe = 1'b1;
			end
			LDI: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = wbImm;
			end
			LD: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = wbMem;
			end
			ST: begin
				ctrl.memWe = 1'b1;
			end
			JMP: begin
				pcSel = PC_IMM;
			end
			// Conditional jumps fall through to PC+1
			JZ: begin
				if (zFlag) begin
					pcSel = PC_IMM;
				end
			end
			JC: begin
				if (cFlag) begin
					pcSel = PC_IMM;
				end
			end
			JR: begin
				pcSel = PC_REG;
			end
			default: begin
				pcSel = PC_INC;
			end
		endcase
	end

endmodule

// File: source/processor.sv
`timescale 1ns/1ps

module processor import cpuPkg::*; (
	input logic clk,
	input logic rst,
	output logic [dataWidth-1:0] instrAddr,
	input logic [dataWidth-1:0] instrData,
	input logic [regAddrWidth-1:0] dbgSel,
	output logic [dataWidth-1:0] dbgData,
	output logic storeValid,
	output logic [dataWidth-1:0] storeAddr,
	output logic [dataWidth-1:0] storeData
);

	ctrlT ctrl;
	pcSelT pcSel;

	logic [dataWidth-1:0] dstData;
	logic [dataWidth-1:0] srcData;
	logic [dataWidth-1:0] wbData;
	logic [dataWidth-1:0] aluResult;
	logic cFlag;
	logic zFlag;

	logic [dataWidth-1:0] nextPc;
	logic [dataWidth-1:0] dataMem [memDepth];
	logic [memAddrWidth-1:0] memAddr;
	logic [dataWidth-1:0] memData;
	logic memWrite;

	decoder decode (
		.instr(instrData),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.ctrl(ctrl),
		.pcSel(pcSel)
	);

	// Port A reads dst, port B reads src
	registerFile regFile (
		.clk(clk),
		.rst(rst),
		.we(ctrl.regWe),
		.wAddr(ctrl.regDst),
		.wData(wbData),
		.rAddrA(ctrl.regDst),
		.rDataA(dstData),
		.rAddrB(ctrl.regSrc),
		.rDataB(srcData),
		.dbgSel(dbgSel),
		.dbgData(dbgData)
	);

	alu aluUnit (
		.clk(clk),
		.rst(rst),
		.op(ctrl.op),
		.flagWe(ctrl.flagWe),
		.a(dstData),
		.b(srcData),
		.result(aluResult),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	// ST addresses by dst, LD by src
	assign memAddr = ctrl.memWe ? dstData[memAddrWidth-1:0] : srcData[memAddrWidth-1:0];
	assign memData = dataMem[memAddr];
	assign memWrite = ctrl.memWe & ~rst;

	always_ff @(posedge clk) begin
		if (memWrite) begin
			dataMem[memAddr] <= srcData;
		end
	end

	// Store observation
	assign storeValid = memWrite;
	assign storeAddr = dstData;
	assign storeData = srcData;

	// Writeback source
	always_comb begin
		case (ctrl.wbSel)
			wbImm: wbData = ctrl.imm;
			wbMem: wbData = memData;
			default: wbData = aluResult;
		endcase
	end

	always_comb begin
		case (pcSel)
			PC_IMM: nextPc = ctrl.imm;
			PC_REG: nextPc = srcData;
			default: nextPc = instrAddr + 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instrAddr <= '0;
		end else begin
			instrAddr <= nextPc;
		end
	end

endmodule

// File: source/processorTop.sv
`timescale 1ns/1ps

module processorTop import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic progWe,
	input logic [memAddrWidth-1:0] progAddr,
	input logic [dataWidth-1:0] progData,
	input logic [regAddrWidth-1:0] dbgSel,
	output logic [dataWidth-1:0] dbgData,
	output logic storeValid,
	output logic [dataWidth-1:0] storeAddr,
	output logic [dataWidth-1:0] storeData
);

	logic [dataWidth-1:0] instrMem [memDepth];
	logic [dataWidth-1:0] instrAddr;
	logic [dataWidth-1:0] instrData;

	// Boot load only while the core is held in reset
	always_ff @(posedge clk) begin
		if (rst && progWe) begin
			instrMem[progAddr] <= progData;
		end
	end

	// Fetch ignores the upper PC bits
	assign instrData = instrMem[instrAddr[memAddrWidth-1:0]];

	processor cpu (
		.clk(clk),
		.rst(rst),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.dbgSel(dbgSel),
		.dbgData(dbgData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [regAddrWidth-1:0] wAddr,
	input logic [dataWidth-1:0] wData,
	input logic [regAddrWidth-1:0] rAddrA,
	output logic [dataWidth-1:0] rDataA,
	input logic [regAddrWidth-1:0] rAddrB,
	output logic [dataWidth-1:0] rDataB,
	input logic [regAddrWidth-1:0] dbgSel,
	output logic [dataWidth-1:0] dbgData
);

	logic [dataWidth-1:0] regs [regCount];

	// Registers come out of reset as zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wAddr] <= wData;
		end
	end

	// Operand reads
	assign rDataA = regs[rAddrA];
	assign rDataB = regs[rAddrB];

	// Debug view, same cycle as dbgSel
	assign dbgData = regs[dbgSel];

endmodule

// File: sources.f
source/cpuPkg.sv
source/registerFile.sv
source/alu.sv
source/decoder.sv
source/processor.sv
source/processorTop.sv
sim/processorTb.sv
